//--- project.f
cpuPkg.sv
programCounter.sv
instrRom.sv
instrFetch.sv
instrDecode.sv
accumulatorAlu.sv
dataRam.sv
accCpu.sv
accCpu_tb.sv

//--- Makefile
# Verilator build and run of the accumulator CPU testbench

obj_dir/VaccCpu_tb: project.f $(wildcard *.sv)
	verilator --binary --timing --top-module accCpu_tb -f project.f

run: obj_dir/VaccCpu_tb
	./obj_dir/VaccCpu_tb

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- accCpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module accCpu_tb;

	import cpuPkg::*;

	// Expected run is about 200 cycles from reset to halt
	localparam int cycleLimit = 400;

	logic clk;
	logic reset;
	logic [pcWidth-1:0] pc;
	logic [instrWidth-1:0] instr;
	logic [dataWidth-1:0] accA;
	logic [dataWidth-1:0] accB;
	logic carry;
	logic zero;

	// ------------------------------
	// Reference model state
	// ------------------------------
	logic [pcWidth-1:0] modelPc;
	logic [dataWidth-1:0] modelA;
	logic [dataWidth-1:0] modelB;
	logic modelCarry;
	logic modelZero;
	logic [dataWidth-1:0] modelMem [ramDepth];

	// Word at the DUT port, executed on the next edge
	logic [instrWidth-1:0] heldInstr;
	logic [pcWidth-1:0] executedPc;
	logic resetAtEdge;
	int cycleCount;
	int haltCount;

	accCpu u_accCpu (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.instr(instr),
		.accA(accA),
		.accB(accB),
		.carry(carry),
		.zero(zero)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// Reset for 4 cycles and dropped just after an edge
	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;
	end

	task automatic checkValue(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, expected, actual);
			$display("Simulation finished: FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	function automatic void resetModel();
		modelPc = '0;
		modelA = '0;
		modelB = '0;
		modelCarry = 1'b0;
		modelZero = 1'b0;
	endfunction

	// ------------------------------
	// One instruction of the model
	// ------------------------------
	function automatic void stepModel(input logic [instrWidth-1:0] ins);
		logic [opWidth-1:0] op;
		logic [argWidth-1:0] arg;
		logic [pcWidth-1:0] nextPc;
		int sum;
		op = ins[instrWidth-1:argWidth];
		arg = ins[argWidth-1:0];
		nextPc = modelPc + 10'd1;
		case (op)
			LDCA: modelA = arg[7:0];
			LDCB: modelB = arg[7:0];
			LDA: modelA = modelMem[arg];
			LDB: modelB = modelMem[arg];
			STA: modelMem[arg] = modelA;
			STB: modelMem[arg] = modelB;
			ADDA: begin
				// Carry out when the true sum passes a byte
				sum = int'(modelA) + int'(modelB);
				modelCarry = (sum > 255);
				modelA = sum[7:0];
				modelZero = (modelA == 8'd0);
			end
			ADDB: begin
				sum = int'(modelA) + int'(modelB);
				modelCarry = (sum > 255);
				modelB = sum[7:0];
				modelZero = (modelB == 8'd0);
			end
			SUBA: begin
				// Borrow when the subtrahend is larger
				modelCarry = (modelA < modelB);
				modelA = modelA - modelB;
				modelZero = (modelA == 8'd0);
			end
			ANDA: begin
				modelA = modelA & modelB;
				modelCarry = 1'b0;
				modelZero = (modelA == 8'd0);
			end
			BACS: if (modelCarry) nextPc = arg;
			BAZS: if (modelZero) nextPc = arg;
			JMP: nextPc = arg;
			default: ;
		endcase
		modelPc = nextPc;
	endfunction

	// Fixed values at known points of the program
	task automatic checkMilestone(input logic [pcWidth-1:0] addr);
		case (addr)
			10'd1: begin
				checkValue("accA", 16'd5, 16'(accA));
				checkValue("accB", 16'd7, 16'(accB));
			end
			10'd4: checkValue("accB", 16'd5, 16'(accB));
			10'd7: begin
				checkValue("accA", 16'd12, 16'(accA));
				checkValue("carry", 16'd0, 16'(carry));
			end
			// BACS with no carry falls through
			10'd8: checkValue("pc", 16'd9, 16'(pc));
			10'd11: begin
				checkValue("accA", 16'd44, 16'(accA));
				checkValue("carry", 16'd1, 16'(carry));
			end
			10'd12: checkValue("pc", 16'd50, 16'(pc));
			10'd51: checkValue("zero", 16'd1, 16'(zero));
			10'd52: checkValue("pc", 16'd60, 16'(pc));
			10'd62: begin
				checkValue("accA", 16'h30, 16'(accA));
				checkValue("carry", 16'd0, 16'(carry));
				checkValue("zero", 16'd0, 16'(zero));
			end
			10'd65: checkValue("zero", 16'd1, 16'(zero));
			// B stored at 63 comes back into A
			10'd66: checkValue("accA", 16'h3C, 16'(accA));
			// Carry was set by the borrow at 68
			10'd69: begin
				checkValue("accA", 16'h41, 16'(accA));
				checkValue("carry", 16'd0, 16'(carry));
			end
			haltAddr: checkValue("pc", 16'(haltAddr), 16'(pc));
			default: ;
		endcase
	endtask

	// Words past the test sequence are NOPs up to the final jump
	task automatic checkFetchedWord();
		if (pc == haltAddr) begin
			checkValue("instr", 16'({JMP, haltAddr}), 16'(instr));
		end else if (pc > 10'd69) begin
			checkValue("instr", 16'({NOP, 10'd0}), 16'(instr));
		end
	endtask

	// ------------------------------
	// Compare process
	// ------------------------------
	initial begin
		cycleCount = 0;
		haltCount = 0;
		heldInstr = '0;
		forever begin
			@(posedge clk);
			resetAtEdge = reset;
			#1;
			cycleCount++;
			if (cycleCount > cycleLimit) begin
				$display("Simulation finished: FAIL");
				$fatal(1, "program did not reach the halt address");
			end
			executedPc = modelPc;
			if (resetAtEdge) begin
				resetModel();
			end else begin
				stepModel(heldInstr);
			end
			checkValue("pc", 16'(modelPc), 16'(pc));
			checkValue("accA", 16'(modelA), 16'(accA));
			checkValue("accB", 16'(modelB), 16'(accB));
			checkValue("carry", 16'(modelCarry), 16'(carry));
			checkValue("zero", 16'(modelZero), 16'(zero));
			if (!resetAtEdge) begin
				checkMilestone(executedPc);
			end
			checkFetchedWord();
			heldInstr = instr;
			haltCount = (pc == haltAddr) ? haltCount + 1 : 0;
			if (haltCount >= 2) begin
				$display("Simulation finished: PASS");
				$finish;
			end
		end
	end

endmodule

`default_nettype wire

//--- accCpu.sv
`timescale 1ns/1ps
`default_nettype none

module accCpu (
	input logic clk,
	input logic reset,
	output logic [cpuPkg::pcWidth-1:0] pc,
	output logic [cpuPkg::instrWidth-1:0] instr,
	output logic [cpuPkg::dataWidth-1:0] accA,
	output logic [cpuPkg::dataWidth-1:0] accB,
	output logic carry,
	output logic zero
);

	import cpuPkg::*;

	// ------------------------------
	// Control and data nets
	// ------------------------------
	logic writeA;
	logic writeB;
	logic selMem;
	logic [1:0] aluOp;
	logic setFlags;
	logic memWrite;
	logic memSelB;
	logic brOnCarry;
	logic brOnZero;
	logic brAlways;
	logic brTaken;
	logic [pcWidth-1:0] brTarget;
	logic [dataWidth-1:0] ramData;
	logic [dataWidth-1:0] storeData;

	instrFetch u_instrFetch (
		.clk(clk),
		.reset(reset),
		.brTaken(brTaken),
		.brTarget(brTarget),
		.pc(pc),
		.instr(instr)
	);

	// Opcode is the upper field of the word
	instrDecode u_instrDecode (
		.opcode(instr[instrWidth-1 -: opWidth]),
		.writeA(writeA),
		.writeB(writeB),
		.selMem(selMem),
		.aluOp(aluOp),
		.setFlags(setFlags),
		.memWrite(memWrite),
		.memSelB(memSelB),
		.brOnCarry(brOnCarry),
		.brOnZero(brOnZero),
		.brAlways(brAlways)
	);

	accumulatorAlu u_accumulatorAlu (
		.clk(clk),
		.reset(reset),
		.writeA(writeA),
		.writeB(writeB),
		.selMem(selMem),
		.aluOp(aluOp),
		.setFlags(setFlags),
		.memSelB(memSelB),
		.brOnCarry(brOnCarry),
		.brOnZero(brOnZero),
		.brAlways(brAlways),
		.arg(instr[argWidth-1:0]),
		.ramData(ramData),
		.accA(accA),
		.accB(accB),
		.carry(carry),
		.zero(zero),
		.storeData(storeData),
		.brTaken(brTaken),
		.brTarget(brTarget)
	);

	// Operand field doubles as the data address
	dataRam u_dataRam (
		.clk(clk),
		.addr(instr[argWidth-1:0]),
		.writeData(storeData),
		.write(memWrite),
		.readData(ramData)
	);

endmodule

`default_nettype wire

//--- dataRam.sv
`timescale 1ns/1ps
`default_nettype none

module dataRam (
	input logic clk,
	input logic [cpuPkg::argWidth-1:0] addr,
	input logic [cpuPkg::dataWidth-1:0] writeData,
	input logic write,
	output logic [cpuPkg::dataWidth-1:0] readData
);

	import cpuPkg::*;

	// One byte per operand address
	logic [dataWidth-1:0] mem [ramDepth];

	// Read path, no clock
	assign readData = mem[addr];

	// Store lands on the rising edge
	always_ff @(posedge clk) begin
		if (write) begin
			mem[addr] <= writeData;
		end
	end

endmodule

`default_nettype wire

//--- accumulatorAlu.sv
`timescale 1ns/1ps
`default_nettype none

module accumulatorAlu (
	input logic clk,
	input logic reset,
	input logic writeA,
	input logic writeB,
	input logic selMem,
	input logic [1:0] aluOp,
	input logic setFlags,
	input logic memSelB,
	input logic brOnCarry,
	input logic brOnZero,
	input logic brAlways,
	input logic [cpuPkg::argWidth-1:0] arg,
	input logic [cpuPkg::dataWidth-1:0] ramData,
	output logic [cpuPkg::dataWidth-1:0] accA,
	output logic [cpuPkg::dataWidth-1:0] accB,
	output logic carry,
	output logic zero,
	output logic [cpuPkg::dataWidth-1:0] storeData,
	output logic brTaken,
	output logic [cpuPkg::pcWidth-1:0] brTarget
);

	import cpuPkg::*;

	// Immediate or memory value for the loads
	logic [dataWidth-1:0] loadValue;
	// Top bit is carry out or borrow
	logic [dataWidth:0] aluResult;

	assign loadValue = selMem ? ramData : arg[dataWidth-1:0];

	// ------------------------------
	// Combinational datapath
	// ------------------------------
	always_comb begin
		case (aluOp)
			ALU_ADD: aluResult = {1'b0, accA} + {1'b0, accB};
			// Wraps past zero, so bit 8 flags a borrow
			ALU_SUB: aluResult = {1'b0, accA} - {1'b0, accB};
			ALU_AND: aluResult = {1'b0, accA & accB};
			default: aluResult = {1'b0, loadValue};
		endcase
	end

	// ------------------------------
	// Accumulators and flags
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			accA <= '0;
			accB <= '0;
			carry <= 1'b0;
			zero <= 1'b0;
		end else begin
			if (writeA) begin
				accA <= aluResult[dataWidth-1:0];
			end
			if (writeB) begin
				accB <= aluResult[dataWidth-1:0];
			end
			// Loads leave the flags alone
			if (setFlags) begin
				carry <= aluResult[dataWidth];
				zero <= (aluResult[dataWidth-1:0] == '0);
			end
		end
	end

	assign storeData = memSelB ? accB : accA;

	// Decision from the flags as they stand now
	assign brTaken = brAlways | (brOnCarry & carry) | (brOnZero & zero);
	assign brTarget = arg;

endmodule

`default_nettype wire

//--- instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
	input logic [cpuPkg::opWidth-1:0] opcode,
	output logic writeA,
	output logic writeB,
	// Load source is RAM, not the immediate
	output logic selMem,
	output logic [1:0] aluOp,
	output logic setFlags,
	output logic memWrite,
	// Store B rather than A
	output logic memSelB,
	output logic brOnCarry,
	output logic brOnZero,
	output logic brAlways
);

	import cpuPkg::*;

	always_comb begin
		// Everything idle unless the opcode says otherwise
		writeA = 1'b0;
		writeB = 1'b0;
		selMem = 1'b0;
		aluOp = ALU_PASS;
		setFlags = 1'b0;
		memWrite = 1'b0;
		memSelB = 1'b0;
		brOnCarry = 1'b0;
		brOnZero = 1'b0;
		brAlways = 1'b0;
		case (opcode)
			// ------------------------------
			// Loads and stores
			// ------------------------------
			LDCA: writeA = 1'b1;
			LDCB: writeB = 1'b1;
			LDA: begin
				writeA = 1'b1;
				selMem = 1'b1;
			end
			LDB: begin
				writeB = 1'b1;
				selMem = 1'b1;
			end
			STA: memWrite = 1'b1;
			STB: begin
				memWrite = 1'b1;
				memSelB = 1'b1;
			end
			// ------------------------------
			// Arithmetic and logic
			// ------------------------------
			ADDA: begin
				writeA = 1'b1;
				aluOp = ALU_ADD;
				setFlags = 1'b1;
			end
			ADDB: begin
				writeB = 1'b1;
				aluOp = ALU_ADD;
				setFlags = 1'b1;
			end
			SUBA: begin
				writeA = 1'b1;
				aluOp = ALU_SUB;
				setFlags = 1'b1;
			end
			ANDA: begin
				writeA = 1'b1;
				aluOp = ALU_AND;
				setFlags = 1'b1;
			end
			// Branches
			BACS: brOnCarry = 1'b1;
			BAZS: brOnZero = 1'b1;
			JMP: brAlways = 1'b1;
			// NOP and unknown codes keep the idle levels
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- instrFetch.sv
`timescale 1ns/1ps
`default_nettype none

module instrFetch (
	input logic clk,
	input logic reset,
	input logic brTaken,
	input logic [cpuPkg::pcWidth-1:0] brTarget,
	output logic [cpuPkg::pcWidth-1:0] pc,
	output logic [cpuPkg::instrWidth-1:0] instr
);

	// Address register for the ROM
	programCounter u_programCounter (
		.clk(clk),
		.reset(reset),
		.brTaken(brTaken),
		.brTarget(brTarget),
		.pc(pc)
	);

	// Instruction shows up in the same cycle as its pc
	instrRom u_instrRom (
		.addr(pc),
		.instr(instr)
	);

endmodule

`default_nettype wire

//--- instrRom.sv
`timescale 1ns/1ps
`default_nettype none

module instrRom (
	input logic [cpuPkg::pcWidth-1:0] addr,
	output logic [cpuPkg::instrWidth-1:0] instr
);

	import cpuPkg::*;

	// Fixed program, read without a clock
	always_comb begin
		case (addr)
			// Constants then a round trip through RAM
			10'd0: instr = {LDCA, 10'd5};
			10'd1: instr = {LDCB, 10'd7};
			10'd2: instr = {NOP, 10'd0};
			10'd3: instr = {STA, 10'h125};
			10'd4: instr = {LDB, 10'h125};
			// Restore B so the sum is 5+7
			10'd5: instr = {LDCB, 10'd7};
			10'd6: instr = {NOP, 10'd0};
			10'd7: instr = {ADDA, 10'd0};
			// No carry here so this falls through
			10'd8: instr = {BACS, 10'd50};
			// 200+100 overflows
			10'd9: instr = {LDCA, 10'd200};
			10'd10: instr = {LDCB, 10'd100};
			10'd11: instr = {ADDA, 10'd0};
			10'd12: instr = {BACS, 10'd50};
			// Subtract equal values to reach zero
			10'd50: instr = {LDCB, 10'd44};
			10'd51: instr = {SUBA, 10'd0};
			10'd52: instr = {BAZS, 10'd60};
			// Logic ops and the B store path
			10'd60: instr = {LDCA, 10'h0F0};
			10'd61: instr = {LDCB, 10'h03C};
			10'd62: instr = {ANDA, 10'd0};
			10'd63: instr = {STB, 10'h200};
			10'd64: instr = {LDCB, 10'h00F};
			10'd65: instr = {ANDA, 10'd0};
			10'd66: instr = {LDA, 10'h200};
			10'd67: instr = {ADDB, 10'd0};
			// 0x3C minus 0x4B needs a borrow
			10'd68: instr = {SUBA, 10'd0};
			// AND with carry set must clear it
			10'd69: instr = {ANDA, 10'd0};
			// Spin here forever
			haltAddr: instr = {JMP, haltAddr};
			default: instr = {NOP, 10'd0};
		endcase
	end

endmodule

`default_nettype wire

//--- programCounter.sv
`timescale 1ns/1ps
`default_nettype none

module programCounter (
	input logic clk,
	input logic reset,
	// Branch decision from the execute stage
	input logic brTaken,
	input logic [cpuPkg::pcWidth-1:0] brTarget,
	output logic [cpuPkg::pcWidth-1:0] pc
);

	import cpuPkg::*;

	// Next fetch address
	// A taken branch wins over the increment
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (brTaken) begin
			// Absolute target from the operand field
			pc <= brTarget;
		end else begin
			// Wraps at the top of the ROM
			pc <= pc + pcWidth'(1);
		end
	end

endmodule

`default_nettype wire

//--- cpuPkg.sv
`default_nettype none

package cpuPkg;

	// ------------------------------
	// Word and field widths
	// ------------------------------
	localparam int instrWidth = 16;
	// Opcode sits in the upper bits of the instruction
	localparam int opWidth = 6;
	// Immediate, data address or branch target
	localparam int argWidth = 10;
	localparam int pcWidth = 10;
	localparam int dataWidth = 8;

	// Data memory size in bytes
	localparam int ramDepth = 1024;

	// Jump-to-self at the end of the program
	localparam logic [pcWidth-1:0] haltAddr = 10'd240;

	// ------------------------------
	// Opcodes
	// ------------------------------
	localparam logic [opWidth-1:0] NOP = 6'h00;
	localparam logic [opWidth-1:0] LDCA = 6'h01;
	localparam logic [opWidth-1:0] LDCB = 6'h02;
	localparam logic [opWidth-1:0] LDA = 6'h03;
	localparam logic [opWidth-1:0] LDB = 6'h04;
	localparam logic [opWidth-1:0] STA = 6'h05;
	localparam logic [opWidth-1:0] STB = 6'h06;
	localparam logic [opWidth-1:0] ADDA = 6'h07;
	localparam logic [opWidth-1:0] ADDB = 6'h08;
	localparam logic [opWidth-1:0] SUBA = 6'h09;
	localparam logic [opWidth-1:0] ANDA = 6'h0A;
	// Conditional branches on the flags
	localparam logic [opWidth-1:0] BACS = 6'h0B;
	localparam logic [opWidth-1:0] BAZS = 6'h0C;
	localparam logic [opWidth-1:0] JMP = 6'h0D;

	// ------------------------------
	// ALU operation select
	// ------------------------------
	// Pass forwards the load value untouched
	localparam logic [1:0] ALU_PASS = 2'd0;
	localparam logic [1:0] ALU_ADD = 2'd1;
	localparam logic [1:0] ALU_SUB = 2'd2;
	localparam logic [1:0] ALU_AND = 2'd3;

endpackage

`default_nettype wire
